//--- source/seg_pkg.sv
`default_nettype none

package seg_pkg;

	// four bcd digits, d0 is the least significant
	typedef struct packed {
		logic [3:0] d3;
		logic [3:0] d2;
		logic [3:0] d1;
		logic [3:0] d0;
	} seg_digits_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// serial display bus, dig_n active low
	typedef struct packed {
		logic       mosi;
		logic       sck;
		logic       ncs;
		logic [3:0] dig_n;
	} seg_bus_t;

	typedef struct packed {
		logic count_en;
		logic display_en;
	} seg_ctrl_t;

	localparam logic [7:0] addr_ctrl  = 8'h00;
	localparam logic [7:0] addr_value = 8'h04;
	localparam logic [7:0] addr_tick  = 8'h08;

	// segment bytes for 9 down to 0
	localparam logic [9:0][7:0] seg_table = {
		8'hE6, 8'hFE, 8'hE0, 8'hBE, 8'hAE,
		8'h66, 8'hEA, 8'hDA, 8'h60, 8'hFC
	};

endpackage

`default_nettype wire

//--- source/seg_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module seg_decoder (
	input  wire logic [3:0] digit,
	output logic [7:0]      segments
);

	// codes 10 to 15 stay dark
	always_comb begin
		if (digit <= 4'd9) begin
			segments = seg_pkg::seg_table[digit];
		end else begin
			segments = 8'h00;
		end
	end

endmodule

`default_nettype wire

//--- source/seg_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module seg_apb_regs #(
	parameter logic [31:0] tick_reset = 32'd50_000_000
) (
	input  wire logic               sys_clk,
	input  wire logic               sys_rst,
	input  wire seg_pkg::apb_req_t  apb_req,
	output seg_pkg::apb_rsp_t       apb_rsp,
	input  wire seg_pkg::seg_digits_t count,
	output seg_pkg::seg_ctrl_t      ctrl,
	output logic [31:0]             tick_period,
	output logic                    load,
	output seg_pkg::seg_digits_t    load_value,
	output logic                    clear
);

	logic        access;
	logic        wr_en;
	logic        sel_ctrl;
	logic        sel_value;
	logic        sel_tick;
	logic        addr_ok;
	logic [31:0] rdata;

	// access phase of a transfer, no wait states
	assign access = apb_req.psel & apb_req.penable;
	assign wr_en  = access & apb_req.pwrite;

	assign sel_ctrl  = (apb_req.paddr == seg_pkg::addr_ctrl);
	assign sel_value = (apb_req.paddr == seg_pkg::addr_value);
	assign sel_tick  = (apb_req.paddr == seg_pkg::addr_tick);
	assign addr_ok   = sel_ctrl | sel_value | sel_tick;

	always_ff @(posedge sys_clk or negedge sys_rst) begin
		if (!sys_rst) begin
			ctrl        <= '0;
			tick_period <= tick_reset;
			load        <= 1'b0;
			clear       <= 1'b0;
		end else begin
			// single cycle pulses
			load  <= wr_en & sel_value;
			clear <= wr_en & sel_ctrl & apb_req.pwdata[2];

			if (wr_en && sel_ctrl) begin
				ctrl.count_en   <= apb_req.pwdata[0];
				ctrl.display_en <= apb_req.pwdata[1];
			end

			if (wr_en && sel_tick) begin
				tick_period <= apb_req.pwdata;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (wr_en && sel_value) begin
			load_value <= apb_req.pwdata[15:0];
		end
	end

	// read mux, unmapped offsets read zero
	always_comb begin
		rdata = '0;
		if (sel_ctrl) begin
			rdata = {30'd0, ctrl.display_en, ctrl.count_en};
		end else if (sel_value) begin
			rdata = {16'd0, count};
		end else if (sel_tick) begin
			rdata = tick_period;
		end
	end

	always_comb begin
		apb_rsp.prdata  = rdata;
		apb_rsp.pready  = apb_req.psel;
		apb_rsp.pslverr = access & ~addr_ok;
	end

endmodule

`default_nettype wire

//--- source/seg_bcd_counter.sv
`timescale 1ns/1ps
`default_nettype none

module seg_bcd_counter (
	input  wire logic                 sys_clk,
	input  wire logic                 sys_rst,
	input  wire seg_pkg::seg_ctrl_t   ctrl,
	input  wire logic [31:0]          tick_period,
	input  wire logic                 load,
	input  wire seg_pkg::seg_digits_t load_value,
	input  wire logic                 clear,
	output seg_pkg::seg_digits_t      count
);

	logic [31:0]     period;
	logic [31:0]     pre_cnt;
	logic            tick;
	logic [3:0][3:0] cur;
	logic [3:0][3:0] nxt;
	logic            carry;

	// zero period behaves like one
	assign period = (tick_period == 32'd0) ? 32'd1 : tick_period;
	assign tick   = ctrl.count_en && (pre_cnt >= period - 32'd1);

	always_ff @(posedge sys_clk or negedge sys_rst) begin
		if (!sys_rst) begin
			pre_cnt <= '0;
		end else if (clear || load || tick) begin
			pre_cnt <= '0;
		end else if (ctrl.count_en) begin
			pre_cnt <= pre_cnt + 32'd1;
		end
	end

	// ripple carry from d0 upward
	always_comb begin
		cur   = count;
		carry = 1'b1;
		for (int i = 0; i < 4; i++) begin
			nxt[i] = cur[i];
			if (carry) begin
				if (cur[i] >= 4'd9) begin
					nxt[i] = 4'd0;
				end else begin
					nxt[i] = cur[i] + 4'd1;
					carry  = 1'b0;
				end
			end
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst) begin
		if (!sys_rst) begin
			count <= '0;
		end else if (clear) begin
			count <= '0;
		end else if (load) begin
			count <= load_value;
		end else if (tick) begin
			count <= nxt;
		end
	end

endmodule

`default_nettype wire

//--- source/seg_scan_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module seg_scan_shifter #(
	parameter int sck_div = 1
) (
	input  wire logic               sys_clk,
	input  wire logic               sys_rst,
	input  wire seg_pkg::seg_ctrl_t ctrl,
	input  wire logic [3:0][7:0]    seg_bytes,
	output seg_pkg::seg_bus_t       seg
);

	localparam int div_w = (sck_div > 1) ? $clog2(sck_div) : 1;

	logic [div_w-1:0] div_cnt;
	logic             step_en;
	logic [6:0]       step;
	logic [1:0]       digit;
	logic [4:0]       phase;
	logic [7:0]       byte_q;
	logic [7:0]       cur_byte;
	logic [3:0]       dig_sel;

	assign step_en = (div_cnt == div_w'(sck_div - 1));

	always_ff @(posedge sys_clk or negedge sys_rst) begin
		if (!sys_rst) begin
			div_cnt <= '0;
		end else if (step_en) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// 72 steps per frame, 18 per digit
	always_ff @(posedge sys_clk or negedge sys_rst) begin
		if (!sys_rst) begin
			step <= '0;
		end else if (step_en) begin
			if (step == 7'd71) begin
				step <= '0;
			end else begin
				step <= step + 7'd1;
			end
		end
	end

	assign digit = 2'(step / 7'd18);
	assign phase = 5'(step % 7'd18);

	// byte is held from the end of local step 0
	always_ff @(posedge sys_clk) begin
		if (step_en && phase == 5'd0) begin
			byte_q <= seg_bytes[digit];
		end
	end

	assign cur_byte = (phase == 5'd0) ? seg_bytes[digit] : byte_q;

	// digit latched at the end of its ncs pulse
	always_ff @(posedge sys_clk or negedge sys_rst) begin
		if (!sys_rst) begin
			dig_sel <= 4'b0000;
		end else if (step_en && phase == 5'd17) begin
			dig_sel <= 4'b0001 << digit;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst) begin
		if (!sys_rst) begin
			seg.mosi  <= 1'b0;
			seg.sck   <= 1'b0;
			seg.ncs   <= 1'b1;
			seg.dig_n <= 4'hF;
		end else begin
			if (phase < 5'd16) begin
				// lsb first, sck high on odd steps
				seg.mosi <= cur_byte[phase[3:1]];
				seg.sck  <= phase[0];
				seg.ncs  <= 1'b1;
			end else begin
				seg.mosi <= 1'b0;
				seg.sck  <= 1'b0;
				seg.ncs  <= 1'b0;
			end
			seg.dig_n <= ctrl.display_en ? ~dig_sel : 4'hF;
		end
	end

endmodule

`default_nettype wire

//--- source/seg_display_top.sv
`timescale 1ns/1ps
`default_nettype none

module seg_display_top #(
	parameter int          sck_div    = 1,
	parameter logic [31:0] tick_reset = 32'd50_000_000
) (
	input  wire logic              sys_clk,
	input  wire logic              sys_rst,
	input  wire seg_pkg::apb_req_t apb_req,
	output seg_pkg::apb_rsp_t      apb_rsp,
	output seg_pkg::seg_bus_t      seg
);

	seg_pkg::seg_ctrl_t   ctrl;
	logic [31:0]          tick_period;
	logic                 load;
	seg_pkg::seg_digits_t load_value;
	logic                 clear;
	seg_pkg::seg_digits_t count;
	logic [3:0][7:0]      seg_bytes;

	seg_apb_regs #(
		.tick_reset(tick_reset)
	) regs0 (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.apb_req    (apb_req),
		.apb_rsp    (apb_rsp),
		.count      (count),
		.ctrl       (ctrl),
		.tick_period(tick_period),
		.load       (load),
		.load_value (load_value),
		.clear      (clear)
	);

	seg_bcd_counter counter0 (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.ctrl       (ctrl),
		.tick_period(tick_period),
		.load       (load),
		.load_value (load_value),
		.clear      (clear),
		.count      (count)
	);

	// one table per digit
	seg_decoder dec0 (.digit(count.d0), .segments(seg_bytes[0]));
	seg_decoder dec1 (.digit(count.d1), .segments(seg_bytes[1]));
	seg_decoder dec2 (.digit(count.d2), .segments(seg_bytes[2]));
	seg_decoder dec3 (.digit(count.d3), .segments(seg_bytes[3]));

	seg_scan_shifter #(
		.sck_div(sck_div)
	) shifter0 (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.ctrl     (ctrl),
		.seg_bytes(seg_bytes),
		.seg      (seg)
	);

endmodule

`default_nettype wire

//--- test/seg_display_assert.sv
`timescale 1ns/1ps
`default_nettype none

module seg_display_assert #(
	parameter int sck_div = 1
) (
	input wire logic              sys_clk,
	input wire logic              sys_rst,
	input wire seg_pkg::apb_req_t apb_req,
	input wire seg_pkg::apb_rsp_t apb_rsp,
	input wire seg_pkg::seg_bus_t seg
);

	int fail_cnt = 0;

	// zero wait state slave
	pready_psel: assert property (@(posedge sys_clk) disable iff (!sys_rst)
		apb_rsp.pready == apb_req.psel) else begin
		fail_cnt++;
		$error("pready does not follow psel");
	end

	pslverr_access: assert property (@(posedge sys_clk) disable iff (!sys_rst)
		apb_rsp.pslverr |-> apb_req.psel && apb_req.penable) else begin
		fail_cnt++;
		$error("pslverr high outside an access phase");
	end

	ncs_sck: assert property (@(posedge sys_clk) disable iff (!sys_rst)
		seg.sck |-> seg.ncs) else begin
		fail_cnt++;
		$error("ncs low while sck is high");
	end

	ncs_fall_sck: assert property (@(posedge sys_clk) disable iff (!sys_rst)
		$fell(seg.ncs) |-> !seg.sck) else begin
		fail_cnt++;
		$error("sck high in the cycle ncs falls");
	end

	// latch pulse is two scan steps wide
	ncs_width: assert property (@(posedge sys_clk) disable iff (!sys_rst)
		$fell(seg.ncs) |-> (!seg.ncs) [*(2 * sck_div)] ##1 seg.ncs) else begin
		fail_cnt++;
		$error("ncs low pulse has the wrong length");
	end

	dig_onehot: assert property (@(posedge sys_clk) disable iff (!sys_rst)
		$onehot0(~seg.dig_n)) else begin
		fail_cnt++;
		$error("more than one digit enable is low");
	end

	reset_idle: assert property (@(posedge sys_clk)
		$rose(sys_rst) |-> !seg.sck && seg.ncs && seg.dig_n == 4'hF) else begin
		fail_cnt++;
		$error("display bus not idle when reset ends");
	end

endmodule

// display side held idle for the register block
bind seg_apb_regs seg_display_assert #(.sck_div(1)) apb_sva (
	.sys_clk, .sys_rst, .apb_req, .apb_rsp,
	.seg(7'b0011111)
);

bind seg_scan_shifter seg_display_assert #(.sck_div(sck_div)) scan_sva (
	.sys_clk, .sys_rst, .seg,
	.apb_req('0), .apb_rsp('0)
);

`default_nettype wire

//--- test/seg_display_tb.sv
`timescale 1ns/1ps
`default_nettype none

module seg_display_tb;

	localparam int sck_div    = 1;
	localparam int frame_clks = 72 * sck_div;
	localparam int limit_clks = 200 * frame_clks + 2000;

	// expected segment bytes for 0 to 9
	localparam logic [7:0] seg_ref [10] = '{8'hFC, 8'h60, 8'hDA, 8'hEA, 8'h66,
		8'hAE, 8'hBE, 8'hE0, 8'hFE, 8'hE6};

	logic              sys_clk;
	logic              sys_rst;
	seg_pkg::apb_req_t apb_req;
	seg_pkg::apb_rsp_t apb_rsp;
	seg_pkg::seg_bus_t seg;
	int                errors;
	int                ncs_falls;
	logic              prev_sck;
	logic              prev_ncs;
	logic [7:0]        shreg;
	logic [7:0]        cap [4];

	seg_display_top #(
		.sck_div(sck_div)
	) dut0 (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp),
		.seg    (seg)
	);

	always #50 sys_clk = ~sys_clk;

	// serial capture, first bit lands in bit 0
	always @(negedge sys_clk) begin
		if (sys_rst) begin
			if (seg.sck && !prev_sck) begin
				shreg = {seg.mosi, shreg[7:1]};
			end
			if (!seg.ncs && prev_ncs) begin
				cap[ncs_falls % 4] = shreg;
				ncs_falls++;
			end
		end
		prev_sck = seg.sck;
		prev_ncs = seg.ncs;
	end

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	function automatic logic mapped(input logic [7:0] addr);
		return addr == seg_pkg::addr_ctrl || addr == seg_pkg::addr_value
			|| addr == seg_pkg::addr_tick;
	endfunction

	// digit rule: 9 and above wrap to 0 and carry
	function automatic logic [15:0] bcd_inc(input logic [15:0] v);
		for (int i = 0; i < 16; i += 4) begin
			if (v[i +: 4] < 4'd9) begin
				v[i +: 4] = v[i +: 4] + 4'd1;
				return v;
			end
			v[i +: 4] = 4'd0;
		end
		return v;
	endfunction

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		@(posedge sys_clk);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
		@(posedge sys_clk);
		apb_req.penable <= 1'b1;
		@(negedge sys_clk);
		check_value("pslverr", apb_rsp.pslverr, !mapped(addr));
		@(posedge sys_clk);
		apb_req <= '0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		@(posedge sys_clk);
		apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
		@(posedge sys_clk);
		apb_req.penable <= 1'b1;
		@(negedge sys_clk);
		data = apb_rsp.prdata;
		check_value("pslverr", apb_rsp.pslverr, !mapped(addr));
		@(posedge sys_clk);
		apb_req <= '0;
	endtask

	task automatic count_check(input logic [15:0] v, input int p, input int w);
		logic [15:0] exp;
		logic [31:0] rd;
		exp = v;
		apb_write(seg_pkg::addr_tick, p);
		apb_write(seg_pkg::addr_value, v);
		apb_read(seg_pkg::addr_value, rd);
		check_value("loaded count", rd, v);
		apb_write(seg_pkg::addr_ctrl, 32'h1);
		repeat (w) @(posedge sys_clk);
		apb_write(seg_pkg::addr_ctrl, 32'h0);
		// enable and disable edges lie w plus three clocks apart
		repeat ((w + 3) / p) exp = bcd_inc(exp);
		apb_read(seg_pkg::addr_value, rd);
		check_value("count", rd, exp);
	endtask

	// the last four latches start after the count has settled
	task automatic check_serial(input logic [15:0] value);
		int start;
		logic [3:0] d;
		start = ncs_falls;
		while (ncs_falls < start + 8) @(posedge sys_clk);
		for (int k = 0; k < 4; k++) begin
			d = value[4*k +: 4];
			check_value($sformatf("segment byte %0d", k), cap[k],
				(d <= 4'd9) ? seg_ref[d] : 8'h00);
		end
	endtask

	initial begin
		repeat (limit_clks) @(posedge sys_clk);
		$display("timeout: test sequence still running after %0d clocks", limit_clks);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		logic [31:0] rd;
		logic [31:0] val;
		logic [7:0]  addr;
		logic [3:0]  exp_dig;
		int          start;
		int          sva_fails;
		void'($urandom(27));
		sys_clk   = 1'b0;
		sys_rst   = 1'b0;
		apb_req   = '0;
		errors    = 0;
		ncs_falls = 0;
		prev_sck  = 1'b0;
		prev_ncs  = 1'b1;
		shreg     = '0;
		repeat (10) @(posedge sys_clk);
		sys_rst <= 1'b1;

		val = $urandom;
		apb_write(seg_pkg::addr_tick, val);
		apb_read(seg_pkg::addr_tick, rd);
		check_value("tick_period", rd, val);
		val = $urandom % 4;
		apb_write(seg_pkg::addr_ctrl, val);
		addr = 8'h0C + 8'($urandom % 200);
		apb_write(addr, 32'hFFFF_FFFF);
		apb_read(addr, rd);
		check_value("unmapped read", rd, 32'h0);
		apb_read(seg_pkg::addr_ctrl, rd);
		check_value("ctrl", rd, val);
		apb_write(seg_pkg::addr_ctrl, 32'h0);

		count_check(16'h0999, 1 + $urandom % 20, 40 + $urandom % 200);
		apb_write(seg_pkg::addr_ctrl, 32'h4);
		apb_read(seg_pkg::addr_value, rd);
		check_value("cleared count", rd, 32'h0);
		count_check(16'h9999, 10, 7);
		count_check(16'h3A7F, 10, 7);

		apb_write(seg_pkg::addr_ctrl, 32'h2);
		check_serial(16'h3A80);
		val = $urandom;
		apb_write(seg_pkg::addr_value, val);
		check_serial(val[15:0]);

		// blanking keeps the scan running
		apb_write(seg_pkg::addr_ctrl, 32'h0);
		@(posedge sys_clk);
		start = ncs_falls;
		repeat (2 * frame_clks) begin
			@(negedge sys_clk);
			check_value("dig_n", seg.dig_n, 4'hF);
		end
		@(posedge sys_clk);
		check_value("ncs falls while blank", ncs_falls - start, 8);
		apb_write(seg_pkg::addr_ctrl, 32'h2);
		@(negedge sys_clk);
		while (seg.ncs) @(negedge sys_clk);
		while (!seg.ncs) @(negedge sys_clk);
		@(posedge sys_clk);
		exp_dig = ~(4'b0001 << ((ncs_falls - 1) % 4));
		@(negedge sys_clk);
		check_value("dig_n", seg.dig_n, exp_dig);

		repeat (4) @(posedge sys_clk);
		sva_fails = dut0.regs0.apb_sva.fail_cnt + dut0.shifter0.scan_sva.fail_cnt;
		$display("errors: %0d check, %0d assertion", errors, sva_fails);
		if (errors == 0 && sva_fails == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
source/seg_pkg.sv
source/seg_decoder.sv
source/seg_apb_regs.sv
source/seg_bcd_counter.sv
source/seg_scan_shifter.sv
source/seg_display_top.sv
test/seg_display_assert.sv
test/seg_display_tb.sv

//--- Bender.yml
package:
  name: seg_display

sources:
  - files:
      - source/seg_pkg.sv
      - source/seg_decoder.sv
      - source/seg_apb_regs.sv
      - source/seg_bcd_counter.sv
      - source/seg_scan_shifter.sv
      - source/seg_display_top.sv
  - target: test
    files:
      - test/seg_display_assert.sv
      - test/seg_display_tb.sv
